//--- turf_defs.svh
`ifndef TURF_DEFS_SVH
`define TURF_DEFS_SVH

// Register bus geometry
`define TURF_ADDR_W     16
`define TURF_DATA_W     32

// Slave select lives in the top nibble of the byte address
`define TURF_SLV_MSB    15
`define TURF_SLV_LSB    12
// Word index inside a slave
`define TURF_REG_MSB    5
`define TURF_REG_LSB    2

// ASCII "TURF"
`define TURF_IDENT      32'h5455_5246

// Date/version word fields
`define TURF_VER_MAJOR  4'd0
`define TURF_VER_MINOR  4'd4
`define TURF_VER_REV    8'd19
`define TURF_FW_DATE    15'd0
`define TURF_REV_B      1'b1

`define TURF_NUM_TIO    4

// 16x baud ticks off the 100 MHz PS clock
// Housekeeping is 82/1024 of ps_clk, GPS is 25/4096
`define TURF_HSK_ADD    82
`define TURF_HSK_ACC_W  10
`define TURF_GPS_ADD    25
`define TURF_GPS_ACC_W  12

`endif

//--- turf_bus_pkg.sv
`default_nettype none

`include "turf_defs.svh"

package turf_bus_pkg;

    localparam int SLV_SEL_W = `TURF_SLV_MSB - `TURF_SLV_LSB + 1;

    typedef logic [`TURF_ADDR_W-1:0] turf_addr_t;
    typedef logic [`TURF_DATA_W-1:0] turf_data_t;

    // Decoded slave field, anything not mapped collapses to SLV_NONE
    typedef enum logic [SLV_SEL_W-1:0] {
        SLV_IDCTRL = 4'd0,
        SLV_GPIO   = 4'd1,
        SLV_NONE   = 4'd15
    } turf_slave_e;

endpackage

`default_nettype wire

//--- turf_reg_pkg.sv
`default_nettype none

`include "turf_defs.svh"

package turf_reg_pkg;

    localparam int REG_IDX_W = `TURF_REG_MSB - `TURF_REG_LSB + 1;

    // ID and control register map
    typedef enum logic [REG_IDX_W-1:0] {
        REG_IDENT        = 4'd0,
        REG_DATEVER      = 4'd1,
        REG_BRIDGE_TYPE  = 4'd2,
        REG_BRIDGE_STAT  = 4'd3,
        REG_BRIDGE_VALID = 4'd4
    } idctrl_reg_e;

    // EMIO GPIO register map
    typedef enum logic [REG_IDX_W-1:0] {
        REG_GPIO_OUT = 4'd0,
        REG_GPIO_TRI = 4'd1,
        REG_GPIO_IN  = 4'd2
    } gpio_reg_e;

    // GPIO bit layout
    localparam int TIO_RESET_LSB    = 12;
    localparam int GPS_TP_LSB       = 10;
    localparam int GPS_EXTINT_LSB   = 8;
    localparam int HSK_COMPLETE_BIT = 2;
    localparam int HSK_IRQ_BIT      = 1;
    localparam int UART_IRQ_BIT     = 0;

endpackage

`default_nettype wire

//--- turf_reg_if.sv
`default_nettype none

// Single-master register bus between the intercon and one slave
interface turf_reg_if
    import turf_bus_pkg::*;
();

    logic       cyc;
    logic       stb;
    logic       we;
    turf_addr_t adr;
    turf_data_t dat_w;
    turf_data_t dat_r;
    logic       ack;

    modport master (
        output cyc, stb, we, adr, dat_w,
        input  dat_r, ack
    );

    modport slave (
        input  cyc, stb, we, adr, dat_w,
        output dat_r, ack
    );

endinterface

`default_nettype wire

//--- serial_tick_gen.sv
`default_nettype none

`include "turf_defs.svh"

// Fractional accumulator, tick rate is ps_clk * ADD / 2**ACC_W
module serial_tick_gen #(
    parameter int unsigned ADD   = `TURF_HSK_ADD,
    parameter int unsigned ACC_W = `TURF_HSK_ACC_W
) (
    input  wire  ps_clk,
    input  wire  rst_n_i,
    output logic tick_o
);

    logic [ACC_W-1:0] acc_q;
    logic [ACC_W:0]   sum;

    assign sum = {1'b0, acc_q} + (ACC_W+1)'(ADD);

    // Tick is the carry, registered
    always_ff @(posedge ps_clk) begin
        if (!rst_n_i) begin
            acc_q  <= '0;
            tick_o <= 1'b0;
        end else begin
            acc_q  <= sum[ACC_W-1:0];
            tick_o <= sum[ACC_W];
        end
    end

    if (ADD < (2 ** (ACC_W - 1))) begin : g_spacing_chk
        tick_spacing: assert property (@(posedge ps_clk) disable iff (!rst_n_i)
            tick_o |=> !tick_o);
    end

endmodule

`default_nettype wire

//--- turf_intercon.sv
`default_nettype none

`include "turf_defs.svh"

module turf_intercon
    import turf_bus_pkg::*;
(
    input  wire         ps_clk,
    input  wire         rst_n_i,
    input  wire         wb_cyc_i,
    input  wire         wb_stb_i,
    input  wire         wb_we_i,
    input  wire turf_addr_t wb_adr_i,
    input  wire turf_data_t wb_dat_i,
    output turf_data_t  wb_dat_o,
    output logic        wb_ack_o,
    turf_reg_if.master  idctrl_o,
    turf_reg_if.master  gpio_o
);

    turf_slave_e slv_dec;
    turf_slave_e slv_q;
    logic        req;
    logic        cyc_q;
    logic        stb_q;
    logic        we_q;
    turf_addr_t  adr_q;
    turf_data_t  dat_q;
    logic        idc_sel;
    logic        gpio_sel;
    logic        none_ack_q;

    always_comb begin
        case (wb_adr_i[`TURF_SLV_MSB:`TURF_SLV_LSB])
            SLV_IDCTRL: slv_dec = SLV_IDCTRL;
            SLV_GPIO:   slv_dec = SLV_GPIO;
            default:    slv_dec = SLV_NONE;
        endcase
    end

    // New request until the reply comes back
    assign req = wb_cyc_i & wb_stb_i & ~wb_ack_o;

    always_ff @(posedge ps_clk) begin
        if (!rst_n_i) begin
            cyc_q <= 1'b0;
            stb_q <= 1'b0;
            slv_q <= SLV_NONE;
        end else begin
            cyc_q <= wb_cyc_i;
            stb_q <= req;
            if (req) begin
                slv_q <= slv_dec;
            end
        end
    end

    // Request payload, held through the ack
    always_ff @(posedge ps_clk) begin
        if (req) begin
            we_q  <= wb_we_i;
            adr_q <= wb_adr_i;
            dat_q <= wb_dat_i;
        end
    end

    ////////////////////////////////////////////////////////////
    // Slave side

    assign idc_sel  = (slv_q == SLV_IDCTRL);
    assign gpio_sel = (slv_q == SLV_GPIO);

    assign idctrl_o.cyc   = cyc_q & idc_sel;
    assign idctrl_o.stb   = stb_q & idc_sel;
    assign idctrl_o.we    = we_q & idc_sel;
    assign idctrl_o.adr   = idc_sel ? adr_q : '0;
    assign idctrl_o.dat_w = idc_sel ? dat_q : '0;

    assign gpio_o.cyc   = cyc_q & gpio_sel;
    assign gpio_o.stb   = stb_q & gpio_sel;
    assign gpio_o.we    = we_q & gpio_sel;
    assign gpio_o.adr   = gpio_sel ? adr_q : '0;
    assign gpio_o.dat_w = gpio_sel ? dat_q : '0;

    // Unmapped space answers itself with the same latency
    always_ff @(posedge ps_clk) begin
        if (!rst_n_i) begin
            none_ack_q <= 1'b0;
        end else begin
            none_ack_q <= stb_q & (slv_q == SLV_NONE) & ~none_ack_q;
        end
    end

    assign wb_ack_o = idctrl_o.ack | gpio_o.ack | none_ack_q;

    always_comb begin
        case (slv_q)
            SLV_IDCTRL: wb_dat_o = idctrl_o.dat_r;
            SLV_GPIO:   wb_dat_o = gpio_o.dat_r;
            default:    wb_dat_o = '0;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Checks

    one_slave_stb: assert property (@(posedge ps_clk) disable iff (!rst_n_i)
        $onehot0({idctrl_o.stb, gpio_o.stb, stb_q && slv_q == SLV_NONE}));

    single_ack: assert property (@(posedge ps_clk) disable iff (!rst_n_i)
        wb_ack_o |=> !wb_ack_o);

endmodule

`default_nettype wire

//--- turf_id_ctrl.sv
`default_nettype none

`include "turf_defs.svh"

module turf_id_ctrl
    import turf_bus_pkg::*;
    import turf_reg_pkg::*;
(
    input  wire                      ps_clk,
    input  wire                      rst_n_i,
    turf_reg_if.slave                bus_i,
    input  wire  [`TURF_NUM_TIO-1:0] bridge_timeout_i,
    input  wire  [`TURF_NUM_TIO-1:0] bridge_invalid_i,
    input  wire  [`TURF_NUM_TIO-1:0] aurora_up_i,
    output logic [7:0]               bridge_type_o
);

    localparam int NUM_TIO = `TURF_NUM_TIO;

    // Revision flag, date, then major/minor/rev
    localparam turf_data_t DATEVERSION = {`TURF_REV_B, `TURF_FW_DATE,
                                          `TURF_VER_MAJOR, `TURF_VER_MINOR,
                                          `TURF_VER_REV};

    idctrl_reg_e          reg_idx;
    logic                 ack_q;
    logic                 wr_en;
    logic                 stat_clr;
    logic [2*NUM_TIO-1:0] clr_mask;
    logic [NUM_TIO-1:0]   timeout_q;
    logic [NUM_TIO-1:0]   invalid_q;
    logic [4*NUM_TIO-1:0] bridge_valid;
    turf_data_t           rdata;

    assign reg_idx = idctrl_reg_e'(bus_i.adr[`TURF_REG_MSB:`TURF_REG_LSB]);

    always_ff @(posedge ps_clk) begin
        if (!rst_n_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= bus_i.cyc & bus_i.stb & ~ack_q;
        end
    end

    // Writes land on the edge closing the ack cycle
    assign wr_en = ack_q & bus_i.we;

    always_ff @(posedge ps_clk) begin
        if (!rst_n_i) begin
            bridge_type_o <= '0;
        end else if (wr_en && reg_idx == REG_BRIDGE_TYPE) begin
            bridge_type_o <= bus_i.dat_w[7:0];
        end
    end

    ////////////////////////////////////////////////////////////
    // Sticky bridge status, timeouts low and invalids above

    assign stat_clr = wr_en && (reg_idx == REG_BRIDGE_STAT);
    assign clr_mask = stat_clr ? bus_i.dat_w[2*NUM_TIO-1:0] : '0;

    always_ff @(posedge ps_clk) begin
        if (!rst_n_i) begin
            timeout_q <= '0;
            invalid_q <= '0;
        end else begin
            // A new event beats a clear on the same bit
            timeout_q <= (timeout_q & ~clr_mask[NUM_TIO-1:0]) | bridge_timeout_i;
            invalid_q <= (invalid_q & ~clr_mask[2*NUM_TIO-1:NUM_TIO]) | bridge_invalid_i;
        end
    end

    // One nibble per bridge: bit 0 always valid, bit 1 is link up
    always_comb begin
        bridge_valid = '0;
        for (int n = 0; n < NUM_TIO; n++) begin
            bridge_valid[4*n]   = 1'b1;
            bridge_valid[4*n+1] = aurora_up_i[n];
        end
    end

    always_comb begin
        case (reg_idx)
            REG_IDENT:        rdata = `TURF_IDENT;
            REG_DATEVER:      rdata = DATEVERSION;
            REG_BRIDGE_TYPE:  rdata = turf_data_t'(bridge_type_o);
            REG_BRIDGE_STAT:  rdata = turf_data_t'({invalid_q, timeout_q});
            REG_BRIDGE_VALID: rdata = turf_data_t'(bridge_valid);
            default:          rdata = '0;
        endcase
    end

    assign bus_i.dat_r = rdata;
    assign bus_i.ack   = ack_q;

    ack_in_stb: assert property (@(posedge ps_clk) disable iff (!rst_n_i)
        bus_i.ack |-> bus_i.stb);

endmodule

`default_nettype wire

//--- emio_gpio_ctrl.sv
`default_nettype none

`include "turf_defs.svh"

module emio_gpio_ctrl
    import turf_bus_pkg::*;
    import turf_reg_pkg::*;
(
    input  wire                      ps_clk,
    input  wire                      rst_n_i,
    turf_reg_if.slave                bus_i,
    input  wire  [`TURF_NUM_TIO-1:0] tio_resetb_i,
    input  wire  [1:0]               gps_timepulse_i,
    input  wire                      hsk_complete_i,
    input  wire                      hsk_irq_i,
    input  wire                      uart_irq_b_i,
    output logic [`TURF_NUM_TIO-1:0] tio_resetb_o,
    output logic [`TURF_NUM_TIO-1:0] tio_resetb_oe_o,
    output logic [1:0]               gps_extint_o
);

    localparam int NUM_GPS = 2;
    // TURFIO resets sit at the top of the EMIO word
    localparam int GPIO_W  = TIO_RESET_LSB + `TURF_NUM_TIO;

    gpio_reg_e         reg_idx;
    logic              ack_q;
    logic              wr_en;
    logic [GPIO_W-1:0] out_q;
    logic [GPIO_W-1:0] tri_q;
    logic [GPIO_W-1:0] in_word;
    turf_data_t        rdata;

    assign reg_idx = gpio_reg_e'(bus_i.adr[`TURF_REG_MSB:`TURF_REG_LSB]);

    always_ff @(posedge ps_clk) begin
        if (!rst_n_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= bus_i.cyc & bus_i.stb & ~ack_q;
        end
    end

    assign wr_en = ack_q & bus_i.we;

    // Everything comes up tristated
    always_ff @(posedge ps_clk) begin
        if (!rst_n_i) begin
            out_q <= '0;
            tri_q <= '1;
        end else if (wr_en) begin
            case (reg_idx)
                REG_GPIO_OUT: out_q <= bus_i.dat_w[GPIO_W-1:0];
                REG_GPIO_TRI: tri_q <= bus_i.dat_w[GPIO_W-1:0];
                default: ;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // Pins

    assign tio_resetb_o    = out_q[TIO_RESET_LSB +: `TURF_NUM_TIO];
    assign tio_resetb_oe_o = ~tri_q[TIO_RESET_LSB +: `TURF_NUM_TIO];
    // EXTINT has no input path, so tristate just means low
    assign gps_extint_o    = out_q[GPS_EXTINT_LSB +: NUM_GPS]
                           & ~tri_q[GPS_EXTINT_LSB +: NUM_GPS];

    always_comb begin
        in_word = '0;
        in_word[TIO_RESET_LSB +: `TURF_NUM_TIO] = tio_resetb_i;
        in_word[GPS_TP_LSB +: NUM_GPS]          = gps_timepulse_i;
        in_word[HSK_COMPLETE_BIT]               = hsk_complete_i;
        in_word[HSK_IRQ_BIT]                    = hsk_irq_i;
        in_word[UART_IRQ_BIT]                   = uart_irq_b_i;
    end

    always_comb begin
        case (reg_idx)
            REG_GPIO_OUT: rdata = turf_data_t'(out_q);
            REG_GPIO_TRI: rdata = turf_data_t'(tri_q);
            REG_GPIO_IN:  rdata = turf_data_t'(in_word);
            default:      rdata = '0;
        endcase
    end

    assign bus_i.dat_r = rdata;
    assign bus_i.ack   = ack_q;

    // Lines tristated by a bus write stay low afterwards
    extint_off_when_tri: assert property (@(posedge ps_clk) disable iff (!rst_n_i)
        wr_en && reg_idx == REG_GPIO_TRI
        |=> (gps_extint_o & $past(bus_i.dat_w[GPS_EXTINT_LSB +: NUM_GPS])) == '0);

endmodule

`default_nettype wire

//--- turf_ctrl_top.sv
`default_nettype none

`include "turf_defs.svh"

module turf_ctrl_top
    import turf_bus_pkg::*;
(
    input  wire                      ps_clk,
    input  wire                      rst_n_i,
    // Register bus from the PS
    input  wire                      wb_cyc_i,
    input  wire                      wb_stb_i,
    input  wire                      wb_we_i,
    input  wire turf_addr_t          wb_adr_i,
    input  wire turf_data_t          wb_dat_i,
    output turf_data_t               wb_dat_o,
    output logic                     wb_ack_o,
    // Crate bridge
    input  wire  [`TURF_NUM_TIO-1:0] bridge_timeout_i,
    input  wire  [`TURF_NUM_TIO-1:0] bridge_invalid_i,
    input  wire  [`TURF_NUM_TIO-1:0] aurora_up_i,
    output logic [7:0]               bridge_type_o,
    // EMIO pins
    input  wire  [`TURF_NUM_TIO-1:0] tio_resetb_i,
    output logic [`TURF_NUM_TIO-1:0] tio_resetb_o,
    output logic [`TURF_NUM_TIO-1:0] tio_resetb_oe_o,
    input  wire  [1:0]               gps_timepulse_i,
    output logic [1:0]               gps_extint_o,
    input  wire                      hsk_complete_i,
    input  wire                      hsk_irq_i,
    input  wire                      uart_irq_b_i,
    // 16x baud ticks
    output logic                     hsk_tick_o,
    output logic                     gps_tick_o
);

    turf_reg_if idctrl_bus ();
    turf_reg_if gpio_bus ();

    turf_intercon u_intercon (
        .ps_clk   (ps_clk),
        .rst_n_i  (rst_n_i),
        .wb_cyc_i (wb_cyc_i),
        .wb_stb_i (wb_stb_i),
        .wb_we_i  (wb_we_i),
        .wb_adr_i (wb_adr_i),
        .wb_dat_i (wb_dat_i),
        .wb_dat_o (wb_dat_o),
        .wb_ack_o (wb_ack_o),
        .idctrl_o (idctrl_bus.master),
        .gpio_o   (gpio_bus.master)
    );

    turf_id_ctrl u_idctrl (
        .ps_clk           (ps_clk),
        .rst_n_i          (rst_n_i),
        .bus_i            (idctrl_bus.slave),
        .bridge_timeout_i (bridge_timeout_i),
        .bridge_invalid_i (bridge_invalid_i),
        .aurora_up_i      (aurora_up_i),
        .bridge_type_o    (bridge_type_o)
    );

    emio_gpio_ctrl u_gpio (
        .ps_clk          (ps_clk),
        .rst_n_i         (rst_n_i),
        .bus_i           (gpio_bus.slave),
        .tio_resetb_i    (tio_resetb_i),
        .gps_timepulse_i (gps_timepulse_i),
        .hsk_complete_i  (hsk_complete_i),
        .hsk_irq_i       (hsk_irq_i),
        .uart_irq_b_i    (uart_irq_b_i),
        .tio_resetb_o    (tio_resetb_o),
        .tio_resetb_oe_o (tio_resetb_oe_o),
        .gps_extint_o    (gps_extint_o)
    );

    serial_tick_gen #(.ADD(`TURF_HSK_ADD), .ACC_W(`TURF_HSK_ACC_W)) u_hsk_tick (
        .ps_clk  (ps_clk),
        .rst_n_i (rst_n_i),
        .tick_o  (hsk_tick_o)
    );

    serial_tick_gen #(.ADD(`TURF_GPS_ADD), .ACC_W(`TURF_GPS_ACC_W)) u_gps_tick (
        .ps_clk  (ps_clk),
        .rst_n_i (rst_n_i),
        .tick_o  (gps_tick_o)
    );

endmodule

`default_nettype wire

//--- tb_turf_ctrl.sv
`default_nettype none

`include "turf_defs.svh"

module tb_turf_ctrl;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int TICK_WINDOW = 10240;

    logic        ps_clk;
    logic        rst_n_i;
    logic        wb_cyc_i;
    logic        wb_stb_i;
    logic        wb_we_i;
    logic [15:0] wb_adr_i;
    logic [31:0] wb_dat_i;
    logic [31:0] wb_dat_o;
    logic        wb_ack_o;
    logic [3:0]  bridge_timeout_i;
    logic [3:0]  bridge_invalid_i;
    logic [3:0]  aurora_up_i;
    logic [7:0]  bridge_type_o;
    logic [3:0]  tio_resetb_i;
    logic [3:0]  tio_resetb_o;
    logic [3:0]  tio_resetb_oe_o;
    logic [1:0]  gps_timepulse_i;
    logic [1:0]  gps_extint_o;
    logic        hsk_complete_i;
    logic        hsk_irq_i;
    logic        uart_irq_b_i;
    logic        hsk_tick_o;
    logic        gps_tick_o;

    // Test steps loaded from the data file
    logic [7:0]  op_q[$];
    logic [31:0] arg_q[$];
    logic [31:0] dat_q[$];
    logic [31:0] exp_q[$];

    int          cycle_cnt;
    int          cycle_limit;
    int          tick_cycles;
    int          hsk_cnt;
    int          gps_cnt;
    int          fd;
    int          rc;
    int          hsk_exp;
    int          gps_exp;
    string       line;
    logic [7:0]  op_c;
    logic [31:0] f_arg;
    logic [31:0] f_dat;
    logic [31:0] f_exp;
    logic [31:0] rd;

    turf_ctrl_top dut_i (
        .ps_clk           (ps_clk),
        .rst_n_i          (rst_n_i),
        .wb_cyc_i         (wb_cyc_i),
        .wb_stb_i         (wb_stb_i),
        .wb_we_i          (wb_we_i),
        .wb_adr_i         (wb_adr_i),
        .wb_dat_i         (wb_dat_i),
        .wb_dat_o         (wb_dat_o),
        .wb_ack_o         (wb_ack_o),
        .bridge_timeout_i (bridge_timeout_i),
        .bridge_invalid_i (bridge_invalid_i),
        .aurora_up_i      (aurora_up_i),
        .bridge_type_o    (bridge_type_o),
        .tio_resetb_i     (tio_resetb_i),
        .tio_resetb_o     (tio_resetb_o),
        .tio_resetb_oe_o  (tio_resetb_oe_o),
        .gps_timepulse_i  (gps_timepulse_i),
        .gps_extint_o     (gps_extint_o),
        .hsk_complete_i   (hsk_complete_i),
        .hsk_irq_i        (hsk_irq_i),
        .uart_irq_b_i     (uart_irq_b_i),
        .hsk_tick_o       (hsk_tick_o),
        .gps_tick_o       (gps_tick_o)
    );

    // 100 ns period
    initial ps_clk = 1'b0;
    always #50 ps_clk = ~ps_clk;

    ////////////////////////////////////////////////////////////
    // Reporting

    task automatic stop_with_error(input string what);
        $display("ERROR at %0d ns: %s", $time, what);
        $display("test failed");
        $fatal(1);
    endtask

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        if (got !== exp) begin
            $display("MISMATCH at %0d ns: %s, got %h, expected %h", $time, what, got, exp);
            $display("test failed");
            $fatal(1);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Watchdog and tick counting

    always @(posedge ps_clk) begin
        cycle_cnt++;
        if (cycle_cnt >= cycle_limit) begin
            stop_with_error("timeout, the test did not finish in time");
        end
    end

    // Sample between edges, window opens with reset release
    always @(negedge ps_clk) begin
        if (rst_n_i && tick_cycles < TICK_WINDOW) begin
            tick_cycles++;
            hsk_cnt += int'(hsk_tick_o);
            gps_cnt += int'(gps_tick_o);
        end
    end

    ////////////////////////////////////////////////////////////
    // Bus and pin tasks, all entered 1 ns after a rising edge

    task automatic bus_access(input logic we, input logic [15:0] adr,
                              input logic [31:0] wdat, output logic [31:0] rdat);
        int waited;
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        wb_we_i  = we;
        wb_adr_i = adr;
        wb_dat_i = wdat;
        waited   = 0;
        do begin
            @(posedge ps_clk);
            #1;
            waited++;
            if (waited > 16) begin
                stop_with_error($sformatf("no ack for bus access to %h", adr));
            end
        end while (!wb_ack_o);
        rdat     = wb_dat_o;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
        // Sampled at edge k, ack after edge k+1
        check_value(32'(waited), 32'd2, $sformatf("ack latency at %h", adr));
        @(posedge ps_clk);
        #1;
    endtask

    task automatic set_pins(input logic [31:0] grp, input logic [31:0] val);
        case (grp)
            0: bridge_timeout_i = val[3:0];
            1: bridge_invalid_i = val[3:0];
            2: aurora_up_i      = val[3:0];
            3: tio_resetb_i     = val[3:0];
            4: gps_timepulse_i  = val[1:0];
            5: {hsk_complete_i, hsk_irq_i, uart_irq_b_i} = val[2:0];
            default: stop_with_error($sformatf("unknown input pin group %0d", grp));
        endcase
        @(posedge ps_clk);
        #1;
        // Bridge status inputs are one-cycle pulses
        bridge_timeout_i = '0;
        bridge_invalid_i = '0;
    endtask

    task automatic check_pins(input logic [31:0] grp, input logic [31:0] exp);
        logic [31:0] got;
        @(posedge ps_clk);
        #1;
        got = '0;
        case (grp)
            0: got = 32'(bridge_type_o);
            1: got = 32'(tio_resetb_o);
            2: got = 32'(tio_resetb_oe_o);
            3: got = 32'(gps_extint_o);
            default: stop_with_error($sformatf("unknown output pin group %0d", grp));
        endcase
        check_value(got, exp, $sformatf("pin group %0d", grp));
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence

    initial begin
        wb_cyc_i         = 1'b0;
        wb_stb_i         = 1'b0;
        wb_we_i          = 1'b0;
        wb_adr_i         = '0;
        wb_dat_i         = '0;
        bridge_timeout_i = '0;
        bridge_invalid_i = '0;
        aurora_up_i      = '0;
        tio_resetb_i     = '0;
        gps_timepulse_i  = '0;
        hsk_complete_i   = 1'b0;
        hsk_irq_i        = 1'b0;
        uart_irq_b_i     = 1'b0;
        rst_n_i          = 1'b0;
        cycle_cnt        = 0;
        cycle_limit      = 11000;
        tick_cycles      = 0;
        hsk_cnt          = 0;
        gps_cnt          = 0;

        fd = $fopen("turf_ctrl_input.txt", "r");
        if (fd == 0) begin
            stop_with_error("cannot open turf_ctrl_input.txt");
        end
        while (!$feof(fd)) begin
            line = "";
            rc = $fgets(line, fd);
            if (line.len() > 1 && line[0] != "#") begin
                rc = $sscanf(line, "%c %h %h %h", op_c, f_arg, f_dat, f_exp);
                if (rc != 4) begin
                    stop_with_error($sformatf("bad line in input file: %s", line));
                end
                op_q.push_back(op_c);
                arg_q.push_back(f_arg);
                dat_q.push_back(f_dat);
                exp_q.push_back(f_exp);
            end
        end
        $fclose(fd);
        cycle_limit = 20 * op_q.size() + 11000;

        repeat (5) @(posedge ps_clk);
        #1;
        rst_n_i = 1'b1;
        check_value(32'(wb_ack_o), 32'd0, "ack after reset");

        foreach (op_q[i]) begin
            case (op_q[i])
                "W": bus_access(1'b1, arg_q[i][15:0], dat_q[i], rd);
                "R": begin
                    bus_access(1'b0, arg_q[i][15:0], '0, rd);
                    check_value(rd, exp_q[i], $sformatf("read of %h, step %0d", arg_q[i], i));
                end
                "S": set_pins(arg_q[i], dat_q[i]);
                "P": check_pins(arg_q[i], exp_q[i]);
                default: stop_with_error($sformatf("unknown operation at step %0d", i));
            endcase
        end

        // Tick rate is ADD / 2**ACC_W of ps_clk, rounded down, within one
        wait (tick_cycles == TICK_WINDOW);
        hsk_exp = (TICK_WINDOW * `TURF_HSK_ADD) >> `TURF_HSK_ACC_W;
        gps_exp = (TICK_WINDOW * `TURF_GPS_ADD) >> `TURF_GPS_ACC_W;
        check_value(32'(hsk_cnt >= hsk_exp - 1 && hsk_cnt <= hsk_exp + 1), 32'd1,
                    $sformatf("hsk ticks %0d, wanted %0d within one", hsk_cnt, hsk_exp));
        check_value(32'(gps_cnt >= gps_exp - 1 && gps_cnt <= gps_exp + 1), 32'd1,
                    $sformatf("gps ticks %0d, wanted %0d within one", gps_cnt, gps_exp));

        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- turf_ctrl_input.txt
# op addr data expected, all hex; W write, R read and compare
# S drives pin group (addr) with data, P checks pin group (addr) against expected
R 0000 00000000 54555246
R 0004 00000000 80000413
P 0000 00000000 00000000
P 0001 00000000 00000000
P 0002 00000000 00000000
P 0003 00000000 00000000
R 1000 00000000 00000000
R 1004 00000000 0000FFFF
R 000C 00000000 00000000
W 0008 123456A5 00000000
R 0008 00000000 000000A5
P 0000 00000000 000000A5
S 0000 00000005 00000000
R 000C 00000000 00000005
S 0001 00000003 00000000
R 000C 00000000 00000035
R 000C 00000000 00000035
W 000C 00000004 00000000
R 000C 00000000 00000031
W 000C 000000FF 00000000
R 000C 00000000 00000000
S 0002 00000000 00000000
R 0010 00000000 00001111
S 0002 00000005 00000000
R 0010 00000000 00001313
S 0002 0000000F 00000000
R 0010 00000000 00003333
W 1000 0000A300 00000000
P 0001 00000000 0000000A
P 0002 00000000 00000000
P 0003 00000000 00000000
W 1004 00000EFF 00000000
P 0001 00000000 0000000A
P 0002 00000000 0000000F
P 0003 00000000 00000001
W 1004 00000CFF 00000000
P 0003 00000000 00000003
W 1000 00005100 00000000
P 0001 00000000 00000005
P 0003 00000000 00000001
R 1000 00000000 00005100
R 1004 00000000 00000CFF
S 0003 00000009 00000000
S 0004 00000002 00000000
S 0005 00000005 00000000
R 1008 00000000 00009805
W 2008 000000FF 00000000
R 2008 00000000 00000000
R 0008 00000000 000000A5
W F004 FFFFFFFF 00000000
R F004 00000000 00000000
R 1004 00000000 00000CFF
R 1000 00000000 00005100

//--- build.f
+incdir+.
turf_bus_pkg.sv
turf_reg_pkg.sv
turf_reg_if.sv
serial_tick_gen.sv
turf_intercon.sv
turf_id_ctrl.sv
emio_gpio_ctrl.sv
turf_ctrl_top.sv
tb_turf_ctrl.sv
